// ==== acc_management.f ====
verilog/acc_pkg.sv
verilog/req_fifo.sv
verilog/req_fifo_arbiter.sv
verilog/acc_channel.sv
verilog/acc_management.sv
test/acc_management_properties.sv
test/acc_management_tb.sv

// ==== Bender.yml ====
package:
  name: acc_management

sources:
  - verilog/acc_pkg.sv
  - verilog/req_fifo.sv
  - verilog/req_fifo_arbiter.sv
  - verilog/acc_channel.sv
  - verilog/acc_management.sv
  - target: test
    files:
      - test/acc_management_properties.sv
      - test/acc_management_tb.sv

// ==== test/acc_cases.txt ====
# name channel base_addr(hex) count(dec) expected_sum(hex)
# Adjacent lines with the same name start together
single_ch0  0 00000100  8 fff8081c
single_ch1  1 12340010  5 a4f7005a
zero_count  0 00000200  0 00000000
dual        0 00010000 12 ffe80042
dual        1 ffff0020 10 0000016d
dual_long   0 0abc0100 16 54301078
dual_long   1 00050f00 14 ffacd25b
dual_short  1 80000000  3 7ffd0003
dual_short  0 00000000  1 ffff0000
dual_reset  0 00002000 12 fff58042
dual_reset  1 00030040  6 ffe8018f

// ==== test/acc_management_tb.sv ====
`default_nettype none

module acc_management_tb import acc_pkg::*; ();

  localparam int NUM_ACCS = 2;
  localparam int FIFO_DEPTH_BITS = 2;
  localparam int MAX_CASES = 32;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                           clk;
  logic                           rst;
  logic [NUM_ACCS-1:0]            rst_accs;
  logic [NUM_ACCS-1:0]            start_accs;
  logic [1:0]                     conf_valid;
  acc_conf_u                      conf;
  logic                           req_rd_en;
  logic [ADDR_WIDTH-1:0]          req_rd_addr;
  logic [TAG_WIDTH-1:0]           req_rd_mdata;
  logic                           req_rd_available;
  logic                           resp_rd_valid;
  logic [DATA_WIDTH-1:0]          resp_rd_data;
  logic [TAG_WIDTH-1:0]           resp_rd_mdata;
  logic [NUM_ACCS-1:0]            acc_done;
  logic [NUM_ACCS*DATA_WIDTH-1:0] acc_sum;

  string                 case_name [MAX_CASES];
  int                    case_chan [MAX_CASES];
  logic [ADDR_WIDTH-1:0] case_base [MAX_CASES];
  logic [QTD_WIDTH-1:0]  case_count [MAX_CASES];
  logic [DATA_WIDTH-1:0] case_sum [MAX_CASES];
  int                    num_cases;

  // Request monitor state
  logic [ADDR_WIDTH-1:0] exp_addr [NUM_ACCS];
  int unsigned           exp_left [NUM_ACCS] = '{default: 0};
  string                 chan_name [NUM_ACCS];
  int                    solo_chan = -1;  // Sole member of a one-channel group

  logic                  seen_en = 1'b0;
  logic [ADDR_WIDTH-1:0] seen_addr;
  logic [TAG_WIDTH-1:0]  seen_tag;
  logic                  pipe_en [2] = '{default: 1'b0};
  logic [ADDR_WIDTH-1:0] pipe_addr [2];
  logic [TAG_WIDTH-1:0]  pipe_tag [2];

  logic        stall_on = 1'b0;
  logic [31:0] lfsr = 32'd76037;
  int          value_errors = 0;
  int          proto_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;

  acc_management #(
    .NUM_ACCS(NUM_ACCS),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] a);
    return {~a[31:16], a[15:0]};
  endfunction

  task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                            input logic [ADDR_WIDTH-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("ERR %s address expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_WIDTH-1:0] exp,
                           input logic [TAG_WIDTH-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("ERR %s tag expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_sum(input string name, input logic [DATA_WIDTH-1:0] exp,
                           input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("ERR %s sum expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("ERR %s flag expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic send_conf(input logic [1:0] view, input logic [CONF_ID_WIDTH-1:0] qid,
                           input logic [31:0] value);
    acc_conf_u word;
    if (view == CONF_QTD) begin
      word.qtd.queue_id = qid;
      word.qtd.reserved = '0;
      word.qtd.count = value;
    end else begin
      word.addr.queue_id = qid;
      word.addr.reserved = '0;
      word.addr.base_addr = value;
    end
    conf_valid <= view;
    conf <= word;
    @(posedge clk);
  endtask

  task automatic run_group(input int first, input int last, input int reset_chan);
    logic [NUM_ACCS-1:0] members;
    logic [NUM_ACCS-1:0] wait_mask;
    int c;
    members = '0;
    @(posedge clk);
    for (int k = first; k <= last; k++) begin
      members[case_chan[k]] = 1'b1;
      send_conf(CONF_ADDR, CONF_ID_WIDTH'(case_chan[k]), case_base[k]);
      send_conf(CONF_QTD, CONF_ID_WIDTH'(case_chan[k]), case_count[k]);
    end
    for (int i = 0; i < NUM_ACCS; i++) begin
      if (!members[i]) begin  // Idle channel takes junk, members keep their run
        send_conf(CONF_ADDR, CONF_ID_WIDTH'(i), 32'hDEAD_0000);
        send_conf(CONF_QTD, CONF_ID_WIDTH'(i), 32'd77);
      end
    end
    send_conf(CONF_QTD, 8'hA5, 32'd99);  // No such queue
    conf_valid <= 2'b00;
    solo_chan = (first == last) ? case_chan[first] : -1;
    for (int k = first; k <= last; k++) begin
      c = case_chan[k];
      exp_addr[c] = case_base[k];
      exp_left[c] = case_count[k];
      chan_name[c] = case_name[k];
    end
    start_accs <= members;
    @(posedge clk);
    start_accs <= '0;
    @(negedge clk);
    for (int k = first; k <= last; k++) begin
      if (case_count[k] != 0) begin
        check_flag(case_name[k], 1'b0, acc_done[case_chan[k]]);
      end
    end
    wait_mask = members;
    if (reset_chan >= 0) begin
      while (acc_done[reset_chan] !== 1'b1) begin  // Reset only once its run is done
        @(negedge clk);
      end
      @(posedge clk);
      rst_accs[reset_chan] <= 1'b1;
      @(posedge clk);
      rst_accs <= '0;
      @(negedge clk);
      check_flag(chan_name[reset_chan], 1'b0, acc_done[reset_chan]);
      wait_mask[reset_chan] = 1'b0;
    end
    do begin
      @(negedge clk);
    end while ((acc_done & wait_mask) != wait_mask);
    for (int k = first; k <= last; k++) begin
      c = case_chan[k];
      if (c != reset_chan) begin
        check_sum(case_name[k], case_sum[k], acc_sum[c*DATA_WIDTH +: DATA_WIDTH]);
        check_addr(case_name[k], case_base[k] + case_count[k], exp_addr[c]);  // Exact count
      end
    end
    if (reset_chan >= 0) begin
      repeat (30) @(negedge clk);
      check_flag(chan_name[reset_chan], 1'b0, acc_done[reset_chan]);
    end
    solo_chan = -1;
  endtask

  // Stall source for the memory port
  always @(posedge clk) begin
    if (stall_on) begin
      req_rd_available <= lfsr[0];
      lfsr <= lfsr_next(lfsr);
    end else begin
      req_rd_available <= 1'b1;
    end
  end

  // Memory answers in order, three cycles after the request
  always @(posedge clk) begin
    pipe_en[0] <= seen_en;
    pipe_addr[0] <= seen_addr;
    pipe_tag[0] <= seen_tag;
    pipe_en[1] <= pipe_en[0];
    pipe_addr[1] <= pipe_addr[0];
    pipe_tag[1] <= pipe_tag[0];
    resp_rd_valid <= pipe_en[1];
    resp_rd_data <= mem_word(pipe_addr[1]);
    resp_rd_mdata <= pipe_tag[1];
  end

  always @(negedge clk) begin : monitor
    int t;
    seen_en = 1'b0;
    if (!rst && req_rd_en === 1'b1) begin
      t = int'(req_rd_mdata);
      seen_en = 1'b1;
      seen_addr = req_rd_addr;
      seen_tag = req_rd_mdata;
      if (solo_chan >= 0) begin
        check_tag(chan_name[solo_chan], TAG_WIDTH'(solo_chan), req_rd_mdata);
      end
      if (t < NUM_ACCS && exp_left[t] != 0) begin
        check_addr(chan_name[t], exp_addr[t], req_rd_addr);
        exp_addr[t] = exp_addr[t] + 1'b1;
        exp_left[t] = exp_left[t] - 1;
      end else begin
        proto_errors++;
        $display("Unexpected request to address %h with tag %0d", req_rd_addr, t);
      end
    end else if (!rst && req_rd_en !== 1'b0) begin
      proto_errors++;
      $display("Read enable is unknown at cycle %0d", cycle_count);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
  end

  initial begin
    wait (cycle_count >= cycle_limit);
    $display("Run timed out after %0d cycles", cycle_count);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int fd;
    int n;
    int ch;
    int first;
    int last;
    int last_first;
    int reset_case;
    int words;
    int asserts;
    string line;
    string nm;
    logic [31:0] base;
    logic [31:0] cnt;
    logic [31:0] sum;
    rst <= 1'b1;
    rst_accs <= '0;
    start_accs <= '0;
    conf_valid <= 2'b00;
    conf <= '0;
    req_rd_available <= 1'b1;
    resp_rd_valid <= 1'b0;
    resp_rd_data <= '0;
    resp_rd_mdata <= '0;
    num_cases = 0;
    fd = $fopen("test/acc_cases.txt", "r");
    if (fd == 0) begin
      proto_errors++;
      $display("Cannot open the cases file test/acc_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" && num_cases < MAX_CASES) begin
          n = $sscanf(line, "%s %d %h %d %h", nm, ch, base, cnt, sum);
          if (n == 5) begin
            case_name[num_cases] = nm;
            case_chan[num_cases] = ch;
            case_base[num_cases] = base;
            case_count[num_cases] = cnt;
            case_sum[num_cases] = sum;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
    last_first = num_cases - 1;
    while (last_first > 0 && case_name[last_first - 1] == case_name[num_cases - 1]) begin
      last_first--;
    end
    // Shortest run of the last group ends first
    reset_case = last_first;
    for (int k = last_first + 1; k < num_cases; k++) begin
      if (case_count[k] < case_count[reset_case]) begin
        reset_case = k;
      end
    end
    // Two passes over every case, then the reset run on the last group
    words = 0;
    for (int k = 0; k < num_cases; k++) begin
      words += 2 * int'(case_count[k]);
      if (k >= last_first) begin
        words += int'(case_count[k]);
      end
    end
    cycle_limit = 20 * words + 200;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag("reset", 1'b0, req_rd_en);
    for (int i = 0; i < NUM_ACCS; i++) begin
      check_flag("reset", 1'b0, acc_done[i]);
    end
    repeat (10) @(negedge clk);  // Monitor flags any request here

    for (int pass = 0; pass < 2; pass++) begin
      stall_on = (pass == 1);
      first = 0;
      while (first < num_cases) begin
        last = first;
        while (last + 1 < num_cases && case_name[last + 1] == case_name[first]) begin
          last++;
        end
        run_group(first, last, -1);
        first = last + 1;
      end
    end
    stall_on = 1'b0;
    if (num_cases > 0) begin
      run_group(last_first, num_cases - 1, case_chan[reset_case]);
    end

    asserts = u_dut.u_req_fifo_arbiter.u_props.assert_fails;
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errors, proto_errors, asserts);
    if (value_errors + proto_errors + asserts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/acc_management_properties.sv ====
`default_nettype none

module acc_management_properties import acc_pkg::*; #(
  parameter int NUM_ACCS = 2
) (
  input wire logic                 clk,
  input wire logic                 rst,
  input wire logic [NUM_ACCS-1:0]  req_en_in,
  input wire logic [NUM_ACCS-1:0]  fifo_almost_full,
  input wire logic [NUM_ACCS-1:0]  fifo_empty,
  input wire logic                 req_en_out,
  input wire logic [TAG_WIDTH-1:0] req_tag_out
);

  int assert_fails = 0;

  for (genvar i = 0; i < NUM_ACCS; i++) begin : g_chan
    // Enable is registered, so slack must have been there one cycle before
    a_write_slack: assert property (@(posedge clk) disable iff (rst)
      req_en_in[i] |-> $past(!fifo_almost_full[i]))
    else begin
      assert_fails++;
      $error("FIFO %0d written without slack", i);
    end
  end

  a_pop_source: assert property (@(posedge clk) disable iff (rst)
    req_en_out |-> !$past(&fifo_empty))
  else begin
    assert_fails++;
    $error("Output request with every FIFO empty the cycle before");
  end

  a_tag_known: assert property (@(posedge clk) disable iff (rst)
    req_en_out |-> !$isunknown(req_tag_out))
  else begin
    assert_fails++;
    $error("Output request with unknown tag");
  end

endmodule

bind req_fifo_arbiter acc_management_properties #(
  .NUM_ACCS(NUM_ACCS)
) u_props (
  .clk(clk),
  .rst(rst),
  .req_en_in(req_en_in),
  .fifo_almost_full(fifo_almost_full),
  .fifo_empty(fifo_empty),
  .req_en_out(req_en_out),
  .req_tag_out(req_tag_out)
);

`default_nettype wire

// ==== verilog/acc_management.sv ====
`default_nettype none

module acc_management import acc_pkg::*; #(
  parameter int NUM_ACCS = 2,
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [NUM_ACCS-1:0]            rst_accs,
  input  wire logic [NUM_ACCS-1:0]            start_accs,
  input  wire logic [1:0]                     conf_valid,
  input  wire acc_conf_u                      conf,
  output logic                                req_rd_en,
  output logic      [ADDR_WIDTH-1:0]          req_rd_addr,
  output logic      [TAG_WIDTH-1:0]           req_rd_mdata,
  input  wire logic                           req_rd_available,
  input  wire logic                           resp_rd_valid,
  input  wire logic [DATA_WIDTH-1:0]          resp_rd_data,
  input  wire logic [TAG_WIDTH-1:0]           resp_rd_mdata,
  output logic      [NUM_ACCS-1:0]            acc_done,
  output logic      [NUM_ACCS*DATA_WIDTH-1:0] acc_sum
);

  logic [NUM_ACCS-1:0]            chan_rst;
  logic [NUM_ACCS-1:0]            chan_req_en;
  logic [NUM_ACCS*ADDR_WIDTH-1:0] chan_req_addr;
  logic [NUM_ACCS*TAG_WIDTH-1:0]  chan_req_tag;
  logic [NUM_ACCS-1:0]            chan_available;

  logic                  arb_en;
  logic [ADDR_WIDTH-1:0] arb_addr;
  logic [TAG_WIDTH-1:0]  arb_tag;

  for (genvar i = 0; i < NUM_ACCS; i++) begin : g_acc
    assign chan_rst[i] = rst | rst_accs[i];

    acc_channel #(
      .QUEUE_ID(i)
    ) u_acc_channel (
      .clk(clk),
      .rst(chan_rst[i]),
      .start(start_accs[i]),
      .conf_valid(conf_valid),
      .conf(conf),
      .available_read(chan_available[i]),
      .request_read(chan_req_en[i]),
      .request_addr(chan_req_addr[i*ADDR_WIDTH +: ADDR_WIDTH]),
      .request_tag(chan_req_tag[i*TAG_WIDTH +: TAG_WIDTH]),
      .read_data_valid(resp_rd_valid),
      .read_queue_id(resp_rd_mdata),
      .read_data(resp_rd_data),
      .acc_done(acc_done[i]),
      .acc_sum(acc_sum[i*DATA_WIDTH +: DATA_WIDTH])
    );
  end

  req_fifo_arbiter #(
    .NUM_ACCS(NUM_ACCS),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_req_fifo_arbiter (
    .clk(clk),
    .rst(rst),
    .req_en_in(chan_req_en),
    .req_addr_in(chan_req_addr),
    .req_tag_in(chan_req_tag),
    .req_available_out(req_rd_available),  // Memory hint goes straight to the arbiter
    .req_available_in(chan_available),
    .req_en_out(arb_en),
    .req_addr_out(arb_addr),
    .req_tag_out(arb_tag)
  );

  // Memory read port register
  always_ff @(posedge clk) begin
    if (rst) begin
      req_rd_en <= 1'b0;
    end else begin
      req_rd_en <= arb_en;
    end
  end

  always_ff @(posedge clk) begin
    if (arb_en) begin
      req_rd_addr <= arb_addr;
      req_rd_mdata <= arb_tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/acc_channel.sv ====
`default_nettype none

module acc_channel import acc_pkg::*; #(
  parameter int QUEUE_ID = 0
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire logic [1:0]            conf_valid,
  input  wire acc_conf_u             conf,
  input  wire logic                  available_read,
  output logic                       request_read,
  output logic      [ADDR_WIDTH-1:0] request_addr,
  output logic      [TAG_WIDTH-1:0]  request_tag,
  input  wire logic                  read_data_valid,
  input  wire logic [TAG_WIDTH-1:0]  read_queue_id,
  input  wire logic [DATA_WIDTH-1:0] read_data,
  output logic                       acc_done,
  output logic      [DATA_WIDTH-1:0] acc_sum
);

  localparam logic [CONF_ID_WIDTH-1:0] CONF_ID = CONF_ID_WIDTH'(QUEUE_ID);
  localparam logic [TAG_WIDTH-1:0]     TAG = TAG_WIDTH'(QUEUE_ID);

  // Configured run
  logic [ADDR_WIDTH-1:0] base_addr;
  logic [QTD_WIDTH-1:0]  qtd;

  // Request side
  logic [QTD_WIDTH-1:0]  issue_left;
  logic [ADDR_WIDTH-1:0] next_addr;
  logic [QTD_WIDTH-1:0]  cur_left;
  logic [ADDR_WIDTH-1:0] cur_addr;
  logic                  issue_go;

  // Response side
  logic [QTD_WIDTH-1:0]  recv_left;
  logic                  resp_match;

  assign request_tag = TAG;

  always_ff @(posedge clk) begin
    if (rst) begin
      base_addr <= '0;
      qtd <= '0;
    end else begin
      if (conf_valid == CONF_ADDR && conf.addr.queue_id == CONF_ID) begin
        base_addr <= conf.addr.base_addr;
      end
      if (conf_valid == CONF_QTD && conf.qtd.queue_id == CONF_ID) begin
        qtd <= conf.qtd.count;
      end
    end
  end

  // Start loads the run so the first request can leave next cycle
  always_comb begin
    if (start) begin
      cur_left = qtd;
      cur_addr = base_addr;
    end else begin
      cur_left = issue_left;
      cur_addr = next_addr;
    end
    issue_go = available_read && (cur_left != '0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      request_read <= 1'b0;
      issue_left <= '0;
    end else begin
      request_read <= issue_go;
      if (issue_go) begin
        issue_left <= cur_left - 1'b1;
      end else begin
        issue_left <= cur_left;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_go) begin
      request_addr <= cur_addr;
      next_addr <= cur_addr + 1'b1;
    end else begin
      next_addr <= cur_addr;
    end
  end

  assign resp_match = read_data_valid && (read_queue_id == TAG);

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_left <= '0;
      acc_done <= 1'b0;
    end else if (start) begin
      recv_left <= qtd;
      acc_done <= (qtd == '0);  // Empty run finishes at once
    end else if (resp_match && recv_left != '0) begin
      recv_left <= recv_left - 1'b1;
      if (recv_left == QTD_WIDTH'(1)) begin
        acc_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      acc_sum <= '0;
    end else if (resp_match && recv_left != '0) begin
      acc_sum <= acc_sum + read_data;  // Wraps at 2**32
    end
  end

endmodule

`default_nettype wire

// ==== verilog/req_fifo_arbiter.sv ====
`default_nettype none

module req_fifo_arbiter import acc_pkg::*; #(
  parameter int NUM_ACCS = 2,
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic [NUM_ACCS-1:0]            req_en_in,
  input  wire logic [NUM_ACCS*ADDR_WIDTH-1:0] req_addr_in,
  input  wire logic [NUM_ACCS*TAG_WIDTH-1:0]  req_tag_in,
  input  wire logic                           req_available_out,
  output logic      [NUM_ACCS-1:0]            req_available_in,
  output logic                                req_en_out,
  output logic      [ADDR_WIDTH-1:0]          req_addr_out,
  output logic      [TAG_WIDTH-1:0]           req_tag_out
);

  localparam int ENTRY_WIDTH = ADDR_WIDTH + TAG_WIDTH;
  localparam int PTR_W = (NUM_ACCS > 1) ? $clog2(NUM_ACCS) : 1;

  logic [NUM_ACCS-1:0]    fifo_empty;
  logic [NUM_ACCS-1:0]    fifo_almost_full;
  logic [NUM_ACCS-1:0]    fifo_rd_en;
  logic [ENTRY_WIDTH-1:0] fifo_rd_data [NUM_ACCS];

  logic [PTR_W-1:0] last_grant;  // Round-robin pointer
  logic [PTR_W-1:0] grant_idx;
  logic             grant_found;
  logic             pop;

  for (genvar i = 0; i < NUM_ACCS; i++) begin : g_fifo
    req_fifo #(
      .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS),
      .WIDTH(ENTRY_WIDTH)
    ) u_req_fifo (
      .clk(clk),
      .rst(rst),
      .wr_en(req_en_in[i]),
      .wr_data({req_addr_in[i*ADDR_WIDTH +: ADDR_WIDTH], req_tag_in[i*TAG_WIDTH +: TAG_WIDTH]}),
      .rd_en(fifo_rd_en[i]),
      .rd_data(fifo_rd_data[i]),
      .empty(fifo_empty[i]),
      .almost_full(fifo_almost_full[i])
    );

    assign req_available_in[i] = ~fifo_almost_full[i];
    assign fifo_rd_en[i] = pop && (grant_idx == PTR_W'(i));
  end

  // Search starts just after the last granted channel
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx = last_grant;
    for (int k = 1; k <= NUM_ACCS; k++) begin
      idx = (int'(last_grant) + k) % NUM_ACCS;
      if (!grant_found && !fifo_empty[idx]) begin
        grant_found = 1'b1;
        grant_idx = PTR_W'(idx);
      end
    end
  end

  assign pop = grant_found && req_available_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_en_out <= 1'b0;
      last_grant <= PTR_W'(NUM_ACCS - 1);  // Channel 0 goes first
    end else begin
      req_en_out <= pop;
      if (pop) begin
        last_grant <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      req_addr_out <= fifo_rd_data[grant_idx][ENTRY_WIDTH-1 -: ADDR_WIDTH];
      req_tag_out  <= fifo_rd_data[grant_idx][TAG_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/req_fifo.sv ====
`default_nettype none

module req_fifo #(
  parameter int FIFO_DEPTH_BITS = 2,
  parameter int WIDTH = 36
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             wr_en,
  input  wire logic [WIDTH-1:0] wr_data,
  input  wire logic             rd_en,
  output logic      [WIDTH-1:0] rd_data,
  output logic                  empty,
  output logic                  almost_full
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

  logic [WIDTH-1:0] mem [DEPTH];

  // One extra bit tells full from empty
  logic [FIFO_DEPTH_BITS:0] wr_ptr;
  logic [FIFO_DEPTH_BITS:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0] used;

  assign used = wr_ptr - rd_ptr;
  assign empty = (used == '0);
  assign almost_full = (used >= (FIFO_DEPTH_BITS + 1)'(DEPTH - 1));  // Fewer than two free

  assign rd_data = mem[rd_ptr[FIFO_DEPTH_BITS-1:0]];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_DEPTH_BITS-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/acc_pkg.sv ====
`default_nettype none

package acc_pkg;

  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int TAG_WIDTH     = 4;
  localparam int QTD_WIDTH     = 32;
  localparam int CONF_ID_WIDTH = 8;

  localparam int CONF_WIDTH = 64;
  localparam int CONF_RSVD_WIDTH = CONF_WIDTH - CONF_ID_WIDTH - ADDR_WIDTH;

  // conf_valid codes
  localparam logic [1:0] CONF_ADDR = 2'b01;
  localparam logic [1:0] CONF_QTD  = 2'b10;

  typedef struct packed {
    logic [CONF_ID_WIDTH-1:0]   queue_id;
    logic [CONF_RSVD_WIDTH-1:0] reserved;
    logic [ADDR_WIDTH-1:0]      base_addr;
  } acc_conf_addr_t;

  typedef struct packed {
    logic [CONF_ID_WIDTH-1:0]   queue_id;
    logic [CONF_RSVD_WIDTH-1:0] reserved;
    logic [QTD_WIDTH-1:0]       count;
  } acc_conf_qtd_t;

  // Same 64-bit word, view picked by conf_valid
  typedef union packed {
    acc_conf_addr_t addr;
    acc_conf_qtd_t  qtd;
  } acc_conf_u;

endpackage

`default_nettype wire
